//--- source/robot_nav_pkg.sv
//========================================
// shared types and constants of the robot
// behavior controller, fixed point words
// are 17-bit sign-magnitude, 8.8 format
//========================================
`default_nettype none

package robot_nav_pkg;

	//========================================
	// fixed point format
	//========================================
	localparam int fix_width = 17;

	localparam logic [fix_width-1:0] safe_dist   = 17'b0_00001111_00000000; // 15.0
	localparam logic [fix_width-1:0] err_band    = 17'b0_00001010_00000000; // 10.0
	localparam logic [fix_width-1:0] vel_fwd_pos = 17'b0_00110010_00000000; // +50.0
	localparam logic [fix_width-1:0] vel_neg     = 17'b1_00110010_00000000; // -50.0
	localparam logic [fix_width-1:0] vel_zero    = '0;

	// one word, seen as a plain distance or as sign plus magnitude
	typedef union packed {
		logic [fix_width-1:0] raw;
		struct packed {
			logic                 sign; // 1 means negative
			logic [fix_width-2:0] mag;
		} sm;
	} fixed_word_u;

	//========================================
	// port bundles
	//========================================
	typedef struct packed {
		fixed_word_u dist_1; // left sensor
		fixed_word_u dist_2; // front sensor
		fixed_word_u dist_3; // right sensor
		fixed_word_u dist_4;
	} sensor_set_t;

	typedef struct packed {
		fixed_word_u err_x;
		fixed_word_u err_y;
	} goal_error_t;

	typedef struct packed {
		logic near_1;
		logic near_2;
		logic near_3;
		logic near_4;
		logic goal_left_far;  // err_y positive and far
		logic goal_right_far; // err_y negative and far
		logic goal_y_within;
		logic goal_ahead_far; // err_x positive and far
	} sense_flags_t;

	typedef enum logic [4:0] {
		st_reset, st_start, st_goal,
		st_check_left, st_dodge_left, st_wait_left, st_clear_left,
		st_check_right, st_dodge_right, st_wait_right, st_clear_right,
		st_check_fwd, st_fwd, st_wait_fwd, st_clear_fwd,
		st_side, st_side_dodge, st_wait_side, st_clear_side
	} behavior_state_e;

	typedef struct packed {
		fixed_word_u vel_x;
		fixed_word_u vel_y;
		logic        go_to_goal;    // 1 go-to-goal, 0 avoid
		logic        enable_time_n; // external timer run level
		logic        clear_time_n;  // external timer clear level
	} motion_cmd_t;

endpackage

`default_nettype wire

//--- source/nav_sense.sv
//========================================
// obstacle and goal direction flags from
// the raw sensor distances and goal error
//========================================
`default_nettype none

module nav_sense
(
	input  wire robot_nav_pkg::sensor_set_t  sensors,
	input  wire robot_nav_pkg::goal_error_t  goal_err,
	output robot_nav_pkg::sense_flags_t      flags
);

	logic y_far;    // |err_y| beyond the band
	logic x_far;    // |err_x| beyond the band

	//========================================
	// error magnitude tests
	//========================================
	always_comb
	begin
		y_far = goal_err.err_y.sm.mag > robot_nav_pkg::err_band[robot_nav_pkg::fix_width-2:0];
		x_far = goal_err.err_x.sm.mag > robot_nav_pkg::err_band[robot_nav_pkg::fix_width-2:0];
	end

	//========================================
	// flag word
	//========================================
	always_comb
	begin
		// at or below the safe distance counts as an obstacle
		flags.near_1 = sensors.dist_1.raw <= robot_nav_pkg::safe_dist;
		flags.near_2 = sensors.dist_2.raw <= robot_nav_pkg::safe_dist;
		flags.near_3 = sensors.dist_3.raw <= robot_nav_pkg::safe_dist;
		flags.near_4 = sensors.dist_4.raw <= robot_nav_pkg::safe_dist;

		flags.goal_left_far  = !goal_err.err_y.sm.sign && y_far;  // goal to the left
		flags.goal_right_far = goal_err.err_y.sm.sign && y_far;   // goal to the right
		flags.goal_y_within  = !y_far;
		flags.goal_ahead_far = !goal_err.err_x.sm.sign && x_far;  // goal well ahead
	end

endmodule

`default_nettype wire

//--- source/behavior_fsm.sv
//========================================
// behavior controller state machine, picks
// go-to-goal or one of three detours and
// waits on the external timer before exit
//========================================
`default_nettype none

module behavior_fsm
(
	input  wire logic                         SC_STATEMACHINE_DESC_CLOCK_50,
	input  wire logic                         SC_STATEMACHINE_DESC_RESET_InHigh,
	input  wire robot_nav_pkg::sense_flags_t  flags,
	input  wire logic                         time_flag_n,
	output robot_nav_pkg::behavior_state_e    state
);

	robot_nav_pkg::behavior_state_e next_state;
	logic any_near;

	assign any_near = flags.near_1 || flags.near_2 || flags.near_3 || flags.near_4;

	//========================================
	// next state logic
	//========================================
	always_comb
	begin
		next_state = state; // hold unless a branch moves on
		case (state)
			robot_nav_pkg::st_reset:
				next_state = robot_nav_pkg::st_start;
			robot_nav_pkg::st_start:
				next_state = robot_nav_pkg::st_goal;
			robot_nav_pkg::st_goal:
				if (any_near)
					next_state = robot_nav_pkg::st_check_left; // obstacle seen

			// left branch, goal on the left with sensor 1 blocked
			robot_nav_pkg::st_check_left:
				if (flags.goal_left_far && flags.near_1)
					next_state = robot_nav_pkg::st_dodge_left;
				else
					next_state = robot_nav_pkg::st_check_right;
			robot_nav_pkg::st_dodge_left:
				if (!flags.near_1)
					next_state = robot_nav_pkg::st_wait_left;
			robot_nav_pkg::st_wait_left:
				if (!time_flag_n)
					next_state = robot_nav_pkg::st_clear_left;
			robot_nav_pkg::st_clear_left:
				next_state = robot_nav_pkg::st_goal;

			// right branch, goal on the right with sensor 3 blocked
			robot_nav_pkg::st_check_right:
				if (flags.goal_right_far && flags.near_3)
					next_state = robot_nav_pkg::st_dodge_right;
				else
					next_state = robot_nav_pkg::st_check_fwd;
			robot_nav_pkg::st_dodge_right:
				if (!flags.near_3)
					next_state = robot_nav_pkg::st_wait_right;
			robot_nav_pkg::st_wait_right:
				if (!time_flag_n)
					next_state = robot_nav_pkg::st_clear_right;
			robot_nav_pkg::st_clear_right:
				next_state = robot_nav_pkg::st_goal;

			// forward branch along sensor 2
			robot_nav_pkg::st_check_fwd:
				if (flags.goal_y_within && flags.goal_ahead_far && flags.near_2)
					next_state = robot_nav_pkg::st_fwd;
				else
					next_state = robot_nav_pkg::st_goal; // no branch matched
			robot_nav_pkg::st_fwd:
				if (!flags.near_2)
					next_state = robot_nav_pkg::st_wait_fwd;
			robot_nav_pkg::st_wait_fwd:
				if (!time_flag_n)
					next_state = robot_nav_pkg::st_clear_fwd;
			robot_nav_pkg::st_clear_fwd:
				next_state = robot_nav_pkg::st_side;

			// right side-step after the forward run
			robot_nav_pkg::st_side:
				if (flags.near_3)
					next_state = robot_nav_pkg::st_side_dodge;
			robot_nav_pkg::st_side_dodge:
				if (!flags.near_3)
					next_state = robot_nav_pkg::st_wait_side;
			robot_nav_pkg::st_wait_side:
				if (!time_flag_n)
					next_state = robot_nav_pkg::st_clear_side;
			robot_nav_pkg::st_clear_side:
				next_state = robot_nav_pkg::st_goal;

			default:
				next_state = robot_nav_pkg::st_reset; // unused codes
		endcase
	end

	//========================================
	// state register
	//========================================
	always_ff @(posedge SC_STATEMACHINE_DESC_CLOCK_50, posedge SC_STATEMACHINE_DESC_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_DESC_RESET_InHigh)
			state <= robot_nav_pkg::st_reset;
		else
			state <= next_state;
	end

endmodule

`default_nettype wire

//--- source/motion_command.sv
//========================================
// Moore output decode, velocities, behavior
// bit and timer levels from the state only
//========================================
`default_nettype none

module motion_command
(
	input  wire robot_nav_pkg::behavior_state_e  state,
	output robot_nav_pkg::motion_cmd_t           cmd
);

	logic goal_mode; // go-to-goal, no motion command
	logic fwd_mode;  // forward detour states
	logic wait_st;
	logic clear_st;

	//========================================
	// state classes
	//========================================
	always_comb
	begin
		goal_mode = 1'b0;
		fwd_mode  = 1'b0;
		wait_st   = 1'b0;
		clear_st  = 1'b0;
		case (state)
			robot_nav_pkg::st_reset, robot_nav_pkg::st_start, robot_nav_pkg::st_goal,
			robot_nav_pkg::st_check_left, robot_nav_pkg::st_check_right,
			robot_nav_pkg::st_check_fwd:
				goal_mode = 1'b1;
			robot_nav_pkg::st_dodge_left, robot_nav_pkg::st_dodge_right,
			robot_nav_pkg::st_side, robot_nav_pkg::st_side_dodge:
				goal_mode = 1'b0; // sideways motion only
			robot_nav_pkg::st_wait_left, robot_nav_pkg::st_wait_right,
			robot_nav_pkg::st_wait_side:
				wait_st = 1'b1;
			robot_nav_pkg::st_clear_left, robot_nav_pkg::st_clear_right,
			robot_nav_pkg::st_clear_side:
				clear_st = 1'b1;
			robot_nav_pkg::st_fwd:
				fwd_mode = 1'b1;
			robot_nav_pkg::st_wait_fwd:
			begin
				fwd_mode = 1'b1;
				wait_st  = 1'b1;
			end
			robot_nav_pkg::st_clear_fwd:
			begin
				fwd_mode = 1'b1;
				clear_st = 1'b1;
			end
			default:
				goal_mode = 1'b1; // safe pattern
		endcase
	end

	//========================================
	// command word
	//========================================
	always_comb
	begin
		cmd.go_to_goal    = goal_mode;
		cmd.vel_x.raw     = fwd_mode ? robot_nav_pkg::vel_fwd_pos : robot_nav_pkg::vel_zero;
		// every sideways avoidance state moves right
		cmd.vel_y.raw     = (goal_mode || fwd_mode) ? robot_nav_pkg::vel_zero
		                                            : robot_nav_pkg::vel_neg;
		cmd.enable_time_n = !wait_st;  // timer runs while waiting
		cmd.clear_time_n  = !clear_st; // one cycle clear pulse
	end

endmodule

`default_nettype wire

//--- source/sc_statemachine_desc.sv
//========================================
// top of the robot behavior controller,
// sensing, state machine and output decode
//========================================
`default_nettype none

module sc_statemachine_desc
(
	input  wire logic                         SC_STATEMACHINE_DESC_CLOCK_50,
	input  wire logic                         SC_STATEMACHINE_DESC_RESET_InHigh,
	input  wire robot_nav_pkg::sensor_set_t   sensors,
	input  wire robot_nav_pkg::goal_error_t   goal_err,
	input  wire logic                         time_flag_n,
	output robot_nav_pkg::motion_cmd_t        cmd
);

	robot_nav_pkg::sense_flags_t    flags; // comb flags into the FSM
	robot_nav_pkg::behavior_state_e state;

	nav_sense i_nav_sense
	(
		.sensors  (sensors),
		.goal_err (goal_err),
		.flags    (flags)
	);

	behavior_fsm i_behavior_fsm
	(
		.SC_STATEMACHINE_DESC_CLOCK_50     (SC_STATEMACHINE_DESC_CLOCK_50),
		.SC_STATEMACHINE_DESC_RESET_InHigh (SC_STATEMACHINE_DESC_RESET_InHigh),
		.flags                             (flags),
		.time_flag_n                       (time_flag_n),
		.state                             (state)
	);

	motion_command i_motion_command
	(
		.state (state),
		.cmd   (cmd)
	);

endmodule

`default_nettype wire

//--- verif/nav_ref_model.svh
//========================================
// reference model of the controller and
// typed compare tasks for cmd, included
// inside the testbench module
//========================================
`ifndef NAV_REF_MODEL_SVH
`define NAV_REF_MODEL_SVH

	robot_nav_pkg::behavior_state_e model_state = robot_nav_pkg::st_reset;
	robot_nav_pkg::behavior_state_e model_next; // state after the coming edge
	robot_nav_pkg::behavior_state_e probe_next;
	robot_nav_pkg::motion_cmd_t     exp_cmd;

	function automatic robot_nav_pkg::motion_cmd_t goal_cmd();
		robot_nav_pkg::motion_cmd_t c;
		c.vel_x.raw     = robot_nav_pkg::vel_zero;
		c.vel_y.raw     = robot_nav_pkg::vel_zero;
		c.go_to_goal    = 1'b1;
		c.enable_time_n = 1'b1; // timer idle
		c.clear_time_n  = 1'b1;
		return c;
	endfunction

	// expected command of cur, and the state the inputs lead to
	function automatic robot_nav_pkg::motion_cmd_t ref_step
	(
		input  robot_nav_pkg::behavior_state_e cur,
		input  robot_nav_pkg::sensor_set_t     s,
		input  robot_nav_pkg::goal_error_t     g,
		input  logic                           tflag_n,
		output robot_nav_pkg::behavior_state_e nxt
	);
		robot_nav_pkg::motion_cmd_t c;
		logic n1, n2, n3, n4, y_far, x_far, fwd, goal_like;
		n1    = s.dist_1.raw <= robot_nav_pkg::safe_dist;
		n2    = s.dist_2.raw <= robot_nav_pkg::safe_dist;
		n3    = s.dist_3.raw <= robot_nav_pkg::safe_dist;
		n4    = s.dist_4.raw <= robot_nav_pkg::safe_dist;
		y_far = {1'b0, g.err_y.sm.mag} > robot_nav_pkg::err_band;
		x_far = {1'b0, g.err_x.sm.mag} > robot_nav_pkg::err_band;
		case (cur)
			robot_nav_pkg::st_reset:       nxt = robot_nav_pkg::st_start;
			robot_nav_pkg::st_start:       nxt = robot_nav_pkg::st_goal;
			robot_nav_pkg::st_goal:
				nxt = (n1 || n2 || n3 || n4) ? robot_nav_pkg::st_check_left : cur;
			robot_nav_pkg::st_check_left:
				nxt = (!g.err_y.sm.sign && y_far && n1) ? robot_nav_pkg::st_dodge_left
				                                         : robot_nav_pkg::st_check_right;
			robot_nav_pkg::st_check_right:
				nxt = (g.err_y.sm.sign && y_far && n3) ? robot_nav_pkg::st_dodge_right
				                                        : robot_nav_pkg::st_check_fwd;
			robot_nav_pkg::st_check_fwd:
				nxt = (!y_far && !g.err_x.sm.sign && x_far && n2) ? robot_nav_pkg::st_fwd
				                                                   : robot_nav_pkg::st_goal;
			robot_nav_pkg::st_dodge_left:  nxt = n1 ? cur : robot_nav_pkg::st_wait_left;
			robot_nav_pkg::st_dodge_right: nxt = n3 ? cur : robot_nav_pkg::st_wait_right;
			robot_nav_pkg::st_fwd:         nxt = n2 ? cur : robot_nav_pkg::st_wait_fwd;
			robot_nav_pkg::st_side:        nxt = n3 ? robot_nav_pkg::st_side_dodge : cur;
			robot_nav_pkg::st_side_dodge:  nxt = n3 ? cur : robot_nav_pkg::st_wait_side;
			robot_nav_pkg::st_wait_left:   nxt = tflag_n ? cur : robot_nav_pkg::st_clear_left;
			robot_nav_pkg::st_wait_right:  nxt = tflag_n ? cur : robot_nav_pkg::st_clear_right;
			robot_nav_pkg::st_wait_fwd:    nxt = tflag_n ? cur : robot_nav_pkg::st_clear_fwd;
			robot_nav_pkg::st_wait_side:   nxt = tflag_n ? cur : robot_nav_pkg::st_clear_side;
			robot_nav_pkg::st_clear_fwd:   nxt = robot_nav_pkg::st_side; // side-step follows
			default:                       nxt = robot_nav_pkg::st_goal; // remaining clears
		endcase
		goal_like = cur inside {robot_nav_pkg::st_reset, robot_nav_pkg::st_start,
		                        robot_nav_pkg::st_goal, robot_nav_pkg::st_check_left,
		                        robot_nav_pkg::st_check_right, robot_nav_pkg::st_check_fwd};
		fwd = cur inside {robot_nav_pkg::st_fwd, robot_nav_pkg::st_wait_fwd,
		                  robot_nav_pkg::st_clear_fwd};
		c = goal_cmd();
		if (!goal_like)
		begin
			c.go_to_goal = 1'b0;
			c.vel_x.raw  = fwd ? robot_nav_pkg::vel_fwd_pos : robot_nav_pkg::vel_zero;
			c.vel_y.raw  = fwd ? robot_nav_pkg::vel_zero : robot_nav_pkg::vel_neg;
		end
		c.enable_time_n = !(cur inside {robot_nav_pkg::st_wait_left, robot_nav_pkg::st_wait_right,
		                                robot_nav_pkg::st_wait_fwd, robot_nav_pkg::st_wait_side});
		c.clear_time_n = !(cur inside {robot_nav_pkg::st_clear_left, robot_nav_pkg::st_clear_right,
		                               robot_nav_pkg::st_clear_fwd, robot_nav_pkg::st_clear_side});
		return c;
	endfunction

	task automatic check_flags_path(input string name, input robot_nav_pkg::fixed_word_u got,
		input robot_nav_pkg::fixed_word_u want);
		if (got.raw !== want.raw)
		begin
			$display("Error: %s got %h expected %h", name, got.raw, want.raw);
			stop_on_failure();
		end
	endtask

	task automatic check_cmd(input robot_nav_pkg::motion_cmd_t got,
		input robot_nav_pkg::motion_cmd_t want);
		check_flags_path("cmd.vel_x", got.vel_x, want.vel_x);
		check_flags_path("cmd.vel_y", got.vel_y, want.vel_y);
		if (got.go_to_goal !== want.go_to_goal)
		begin
			$display("Error: cmd.go_to_goal got %h expected %h", got.go_to_goal, want.go_to_goal);
			stop_on_failure();
		end
		if (got.enable_time_n !== want.enable_time_n)
		begin
			$display("Error: cmd.enable_time_n got %h expected %h",
			         got.enable_time_n, want.enable_time_n);
			stop_on_failure();
		end
		if (got.clear_time_n !== want.clear_time_n)
		begin
			$display("Error: cmd.clear_time_n got %h expected %h",
			         got.clear_time_n, want.clear_time_n);
			stop_on_failure();
		end
	endtask

`endif

//--- verif/tb_sc_statemachine_desc.sv
//========================================
// testbench of the behavior controller,
// directed detours then random cycles,
// cmd compared with a model every cycle
//========================================
`default_nettype none

module tb_sc_statemachine_desc;

	logic                        clk;
	logic                        rst;
	robot_nav_pkg::sensor_set_t  sensors;
	robot_nav_pkg::goal_error_t  goal_err;
	logic                        time_flag_n;
	robot_nav_pkg::motion_cmd_t  cmd;
	integer                      seed = 32'h9fb76e9d;

	`include "nav_ref_model.svh"

	sc_statemachine_desc i_dut
	(
		.SC_STATEMACHINE_DESC_CLOCK_50     (clk),
		.SC_STATEMACHINE_DESC_RESET_InHigh (rst),
		.sensors                           (sensors),
		.goal_err                          (goal_err),
		.time_flag_n                       (time_flag_n),
		.cmd                               (cmd)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_on_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	function automatic robot_nav_pkg::fixed_word_u to_fixed(input int value);
		robot_nav_pkg::fixed_word_u w;
		int mag;
		mag       = (value < 0) ? -value : value;
		w.sm.sign = value < 0;
		w.sm.mag  = {mag[7:0], 8'h00}; // whole units only
		return w;
	endfunction

	task automatic drive_sensors(input int d1, input int d2, input int d3, input int d4);
		sensors.dist_1 = to_fixed(d1);
		sensors.dist_2 = to_fixed(d2);
		sensors.dist_3 = to_fixed(d3);
		sensors.dist_4 = to_fixed(d4);
	endtask

	task automatic drive_error(input int x, input int y);
		goal_err.err_x = to_fixed(x);
		goal_err.err_y = to_fixed(y);
	endtask

	task automatic wait_state(input robot_nav_pkg::behavior_state_e target);
		int n;
		n = 0;
		while (model_state != target && n < 40)
		begin
			@(negedge clk);
			n++;
		end
		if (model_state != target)
		begin
			$display("timeout, the controller never reached state %s", target.name());
			stop_on_failure();
		end
	endtask

	// obstacle on one sensor, clear it, then let the timer expire
	task automatic run_detour(input int d1, input int d2, input int d3,
		input robot_nav_pkg::behavior_state_e move_s, input robot_nav_pkg::behavior_state_e wait_s,
		input robot_nav_pkg::behavior_state_e clear_s);
		int hold;
		drive_sensors(d1, d2, d3, 100);
		wait_state(move_s);
		repeat (4) @(negedge clk);
		drive_sensors(100, 100, 100, 100);
		wait_state(wait_s);
		hold = {$random(seed)} % 6 + 2;
		repeat (hold) @(negedge clk); // timer still running
		time_flag_n = 1'b0;
		wait_state(clear_s);
		time_flag_n = 1'b1;
	endtask

	// model steps with the DUT on every rising edge
	always @(posedge clk, posedge rst)
	begin
		if (rst)
			model_state <= robot_nav_pkg::st_reset;
		else
		begin
			void'(ref_step(model_state, sensors, goal_err, time_flag_n, model_next));
			model_state <= model_next;
		end
	end

	always @(negedge clk)
	begin
		exp_cmd = ref_step(model_state, sensors, goal_err, time_flag_n, probe_next);
		check_cmd(cmd, exp_cmd);
	end

	initial
	begin
		rst         = 1'b1;
		time_flag_n = 1'b1;
		drive_sensors(100, 100, 100, 100);
		drive_error(0, 0);
		repeat (8) @(negedge clk);
		rst = 1'b0;
		repeat (10)
		begin
			@(negedge clk);
			check_cmd(cmd, goal_cmd()); // clear road, goal pattern
		end

		drive_error(0, 20);
		// sensor 1 exactly at the safe distance
		run_detour(15, 100, 100, robot_nav_pkg::st_dodge_left, robot_nav_pkg::st_wait_left,
		           robot_nav_pkg::st_clear_left);
		wait_state(robot_nav_pkg::st_goal);
		drive_error(0, -20);
		run_detour(100, 100, 5, robot_nav_pkg::st_dodge_right, robot_nav_pkg::st_wait_right,
		           robot_nav_pkg::st_clear_right);
		wait_state(robot_nav_pkg::st_goal);

		//========================================
		// forward run and right side-step
		//========================================
		drive_error(30, 0);
		run_detour(100, 5, 100, robot_nav_pkg::st_fwd, robot_nav_pkg::st_wait_fwd,
		           robot_nav_pkg::st_clear_fwd);
		wait_state(robot_nav_pkg::st_side);
		repeat (3) @(negedge clk);
		run_detour(100, 100, 5, robot_nav_pkg::st_side_dodge, robot_nav_pkg::st_wait_side,
		           robot_nav_pkg::st_clear_side);
		wait_state(robot_nav_pkg::st_goal);

		drive_error(0, 0);
		drive_sensors(100, 100, 100, 5); // sensor 4 has no detour
		wait_state(robot_nav_pkg::st_check_fwd);
		check_cmd(cmd, goal_cmd());
		drive_sensors(100, 100, 100, 100);
		wait_state(robot_nav_pkg::st_goal);
		drive_error(0, -20);
		drive_sensors(5, 100, 100, 100); // goal on the wrong side
		wait_state(robot_nav_pkg::st_check_fwd);
		check_cmd(cmd, goal_cmd());
		drive_sensors(100, 100, 100, 100);
		wait_state(robot_nav_pkg::st_goal);

		//========================================
		// random inputs, model comparison only
		//========================================
		for (int i = 0; i < 400; i++)
		begin
			@(negedge clk);
			sensors.dist_1.raw     = {$random(seed)} % 17'h2000;
			sensors.dist_2.raw     = {$random(seed)} % 17'h2000;
			sensors.dist_3.raw     = {$random(seed)} % 17'h2000;
			sensors.dist_4.raw     = {$random(seed)} % 17'h2000;
			goal_err.err_x.sm.sign = $random(seed);
			goal_err.err_x.sm.mag  = {$random(seed)} % 16'h1800;
			goal_err.err_y.sm.sign = $random(seed);
			goal_err.err_y.sm.mag  = {$random(seed)} % 16'h1800;
			time_flag_n            = ($random(seed) & 3) != 0; // expires now and then
		end
		repeat (2) @(negedge clk);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sc_statemachine_desc.f
+incdir+verif
source/robot_nav_pkg.sv
source/nav_sense.sv
source/behavior_fsm.sv
source/motion_command.sv
source/sc_statemachine_desc.sv
verif/tb_sc_statemachine_desc.sv
